// ==== dv/bmem_model.sv ====
`timescale 1ns/1ps
`include "frontend_config.svh"

module bmem_model (
    input  logic                    clk,
    input  logic                    rst,
    input  fetch_types_pkg::addr_t  addr_i,
    input  logic                    read_i,
    output logic                    ready_o,
    output fetch_types_pkg::addr_t  raddr_o,
    output mem_types_pkg::beat_t    rdata_o,
    output logic                    rvalid_o,
    output logic                    busy_o
);

    import fetch_types_pkg::*;
    import mem_types_pkg::*;

    localparam logic [31:0] SEED = 32'hb640_50ce;

    logic [31:0] lfsr;
    logic        busy;
    addr_t       base;
    int          beat;
    int          gap;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic inst_t mem_word(input addr_t a);
        return {a[15:0], ~a[15:0]};
    endfunction

    task automatic take_bits(input int n, output int bits);
        bits = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            bits = (bits << 1) | int'(lfsr[0]);
        end
    endtask

    initial begin
        ready_o  = 1'b0;
        raddr_o  = '0;
        rdata_o  = '0;
        rvalid_o = 1'b0;
        busy_o   = 1'b0;
        lfsr     = SEED;
        busy     = 1'b0;
        base     = '0;
        beat     = 0;
        gap      = 0;
    end

    always @(posedge clk) begin
        int r;
        if (rst) begin
            lfsr     = SEED;
            busy     = 1'b0;
            ready_o  <= 1'b0;
            rvalid_o <= 1'b0;
            busy_o   <= 1'b0;
        end else begin
            rvalid_o <= 1'b0;
            take_bits(2, r);
            ready_o <= r != 0;                          // low about one cycle in four
            if (read_i && !busy) begin
                busy = 1'b1;
                base = addr_i;
                beat = 0;
                take_bits(2, gap);                      // first beat also waits 0 to 3 cycles
            end else if (busy) begin
                if (gap > 0) begin
                    gap = gap - 1;
                end else begin
                    rvalid_o <= 1'b1;
                    raddr_o  <= base + addr_t'(8 * beat);
                    rdata_o  <= {mem_word(base + addr_t'(8 * beat + 4)),
                                 mem_word(base + addr_t'(8 * beat))};
                    beat = beat + 1;
                    if (beat == `BURST_BEATS) begin
                        busy = 1'b0;
                    end else begin
                        take_bits(2, gap);
                    end
                end
            end
            busy_o <= busy;
        end
    end

endmodule : bmem_model

// ==== dv/tb_cpu_frontend.sv ====
`timescale 1ns/1ps
`include "frontend_config.svh"

module tb_cpu_frontend;

    import fetch_types_pkg::*;
    import mem_types_pkg::*;

    localparam int NUM_ROWS   = 8;
    localparam int WAIT_LIMIT = 400;

    logic  clk;
    logic  rst;
    addr_t bmem_addr;
    logic  bmem_read;
    logic  bmem_ready;
    addr_t bmem_raddr;
    beat_t bmem_rdata;
    logic  bmem_rvalid;
    logic  bmem_busy;
    logic  dequeue;
    logic  redirect;
    addr_t redirect_addr;
    inst_t inst;
    addr_t pc;
    logic  valid;

    logic  row_redirect [NUM_ROWS];
    addr_t row_target   [NUM_ROWS];
    int    row_count    [NUM_ROWS];
    int    row_stall    [NUM_ROWS];
    logic  row_cached   [NUM_ROWS];   // every fetch of the row should hit

    addr_t exp_pc;
    int    read_cnt;
    int    mismatch_cnt;
    int    protocol_cnt;
    int    timeout_cnt;

    cpu_frontend uut (
        .clk(clk), .rst(rst),
        .bmem_addr_o(bmem_addr), .bmem_read_o(bmem_read), .bmem_ready_i(bmem_ready),
        .bmem_raddr_i(bmem_raddr), .bmem_rdata_i(bmem_rdata), .bmem_rvalid_i(bmem_rvalid),
        .dequeue_i(dequeue), .redirect_i(redirect), .redirect_addr_i(redirect_addr),
        .inst_o(inst), .pc_o(pc), .valid_o(valid)
    );

    bmem_model bmem_i (
        .clk(clk), .rst(rst), .addr_i(bmem_addr), .read_i(bmem_read),
        .ready_o(bmem_ready), .raddr_o(bmem_raddr), .rdata_o(bmem_rdata),
        .rvalid_o(bmem_rvalid), .busy_o(bmem_busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (bmem_read) begin
                read_cnt <= read_cnt + 1;
                assert (bmem_addr[4:0] == 5'd0) else begin
                    mismatch_cnt = mismatch_cnt + 1;
                    $display("MISMATCH at %0t: bmem_addr %h is not line aligned",
                             $time, bmem_addr);
                end
            end
            assert (!(bmem_read && !bmem_ready)) else begin
                protocol_cnt = protocol_cnt + 1;
                $display("bmem_read pulsed at %0t while memory was not ready", $time);
            end
            assert (!(bmem_read && bmem_busy)) else begin
                protocol_cnt = protocol_cnt + 1;
                $display("bmem_read pulsed at %0t while a burst was still running", $time);
            end
        end
    end

    function automatic inst_t expected_inst(input addr_t a);
        return {a[15:0], ~a[15:0]};
    endfunction

    task automatic set_row(input int i, input logic redir, input addr_t target,
                           input int count, input int stall, input logic cached);
        row_redirect[i] = redir;
        row_target[i]   = target;
        row_count[i]    = count;
        row_stall[i]    = stall;
        row_cached[i]   = cached;
    endtask

    task automatic end_run();
        @(negedge clk);
        $display("errors: %0d mismatches, %0d protocol, %0d timeouts",
                 mismatch_cnt, protocol_cnt, timeout_cnt);
        if (mismatch_cnt + protocol_cnt + timeout_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    task automatic apply_redirect(input addr_t target);
        redirect      <= 1'b1;
        redirect_addr <= target;
        @(posedge clk);
        redirect <= 1'b0;
        @(posedge clk);
        assert (!valid) else begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: valid_o high the cycle after redirect to %h", $time, target);
        end
        exp_pc = target;
    endtask

    task automatic pop_and_check();
        int waited;
        waited = 0;
        @(posedge clk);
        while (!valid && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clk);
        end
        if (!valid) begin
            timeout_cnt++;
            $display("no instruction came out within %0d cycles, waiting for pc %h",
                     WAIT_LIMIT, exp_pc);
            end_run();
        end else begin
            assert (pc == exp_pc) else begin
                mismatch_cnt++;
                $display("MISMATCH at %0t: pc %h, expected %h", $time, pc, exp_pc);
            end
            assert (inst == expected_inst(pc)) else begin
                mismatch_cnt++;
                $display("MISMATCH at %0t: inst %h at pc %h, expected %h",
                         $time, inst, pc, expected_inst(pc));
            end
            dequeue <= 1'b1;
            @(posedge clk);
            dequeue <= 1'b0;
            exp_pc = exp_pc + 32'd4;
        end
    endtask

    task automatic run_row(input int r);
        int reads_before;
        reads_before = read_cnt;
        if (row_redirect[r]) begin
            apply_redirect(row_target[r]);
        end
        for (int i = 0; i < row_count[r]; i++) begin
            pop_and_check();
        end
        if (row_cached[r]) begin
            assert (read_cnt == reads_before) else begin
                mismatch_cnt++;
                $display("MISMATCH at %0t: %0d memory reads while refetching cached lines",
                         $time, read_cnt - reads_before);
            end
        end
        repeat (row_stall[r]) @(posedge clk);   // dequeue held low, queue fills
    endtask

    initial begin
        rst           = 1'b1;
        dequeue       = 1'b0;
        redirect      = 1'b0;
        redirect_addr = '0;
        read_cnt      = 0;
        mismatch_cnt  = 0;
        protocol_cnt  = 0;
        timeout_cnt   = 0;
        exp_pc        = `RESET_PC;
        set_row(0, 1'b0, '0, 24, 120, 1'b0);
        set_row(1, 1'b1, `RESET_PC, 16, 40, 1'b1);             // lines 0 to 3 already filled
        set_row(2, 1'b1, `RESET_PC + 32'h200, 12, 0, 1'b0);    // same sets, new tag
        set_row(3, 1'b1, `RESET_PC + 32'h1f4, 20, 0, 1'b0);    // redirect while fetching
        set_row(4, 1'b1, `RESET_PC + 32'h08, 10, 150, 1'b0);
        set_row(5, 1'b0, '0, 30, 0, 1'b0);
        set_row(6, 1'b1, 32'h0000_1000, 20, 10, 1'b0);
        set_row(7, 1'b0, '0, 16, 0, 1'b0);
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        end_run();
    end

endmodule : tb_cpu_frontend

// ==== hw/cacheline_adapter.sv ====
`timescale 1ns/1ps
`include "frontend_config.svh"

module cacheline_adapter (
    input  logic                       clk,
    input  logic                       rst,

    input  mem_types_pkg::beat_t       bmem_rdata_i,
    input  logic                       bmem_rvalid_i,

    output mem_types_pkg::cacheline_t  line_o,
    output logic                       line_valid_o
);

    import mem_types_pkg::*;

    localparam int BEAT_BITS = $bits(beat_t);
    localparam int LINE_BITS = $bits(cacheline_t);
    localparam int CNT_W     = $clog2(`BURST_BEATS);

    logic [CNT_W-1:0] beat_cnt_q;
    logic             last_beat;

    if (`BURST_BEATS * BEAT_BITS != LINE_BITS) begin : g_size_check
        $error("cacheline_adapter: burst does not fill one cache line");
    end

    assign last_beat = beat_cnt_q == CNT_W'(`BURST_BEATS - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt_q   <= '0;
            line_valid_o <= 1'b0;
        end else begin
            line_valid_o <= bmem_rvalid_i && last_beat;    // one cycle after the final beat
            if (bmem_rvalid_i) begin
                beat_cnt_q <= last_beat ? '0 : beat_cnt_q + 1'b1;
            end
        end
    end

    // beats shift in from the top, so the first one ends up in the lowest bits
    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            line_o <= {bmem_rdata_i, line_o[LINE_BITS-1:BEAT_BITS]};
        end
    end

endmodule : cacheline_adapter

// ==== hw/cpu_frontend.sv ====
`timescale 1ns/1ps
`include "frontend_config.svh"

module cpu_frontend (
    input  logic                    clk,
    input  logic                    rst,

    output fetch_types_pkg::addr_t  bmem_addr_o,
    output logic                    bmem_read_o,
    input  logic                    bmem_ready_i,
    input  fetch_types_pkg::addr_t  bmem_raddr_i,
    input  mem_types_pkg::beat_t    bmem_rdata_i,
    input  logic                    bmem_rvalid_i,

    input  logic                    dequeue_i,
    input  logic                    redirect_i,
    input  fetch_types_pkg::addr_t  redirect_addr_i,

    output fetch_types_pkg::inst_t  inst_o,
    output fetch_types_pkg::addr_t  pc_o,
    output logic                    valid_o
);

    import fetch_types_pkg::*;
    import mem_types_pkg::*;

    localparam int BEAT_W = $clog2(`BURST_BEATS);

    addr_t             ufp_addr;
    logic              ufp_rmask;
    inst_t             ufp_rdata;
    logic              ufp_resp;
    logic              dfp_read;
    cacheline_t        line;
    logic              line_valid;
    logic              enqueue;
    logic              iq_full;
    logic              iq_empty;

    addr_t             line_addr_q;      // line requested by the last bmem_read
    logic [BEAT_W-1:0] beat_cnt_q;

    fetch_ctrl fetch_ctrl_i (
        .clk             (clk),
        .rst             (rst),
        .queue_full_i    (iq_full),
        .ufp_resp_i      (ufp_resp),
        .redirect_i      (redirect_i),
        .redirect_addr_i (redirect_addr_i),
        .dfp_read_i      (dfp_read),
        .bmem_ready_i    (bmem_ready_i),
        .ufp_addr_o      (ufp_addr),
        .ufp_rmask_o     (ufp_rmask),
        .enqueue_o       (enqueue),
        .bmem_read_o     (bmem_read_o)
    );

    icache icache_i (
        .clk         (clk),
        .rst         (rst),
        .ufp_addr_i  (ufp_addr),
        .ufp_rmask_i (ufp_rmask),
        .ufp_rdata_o (ufp_rdata),
        .ufp_resp_o  (ufp_resp),
        .dfp_addr_o  (bmem_addr_o),
        .dfp_read_o  (dfp_read),
        .dfp_rdata_i (line),
        .dfp_resp_i  (line_valid)
    );

    cacheline_adapter cacheline_adapter_i (
        .clk           (clk),
        .rst           (rst),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .line_o        (line),
        .line_valid_o  (line_valid)
    );

    fetch_queue #(.DATA_WIDTH($bits(inst_t)), .QUEUE_DEPTH(`IQUEUE_DEPTH)) iqueue_i (
        .clk       (clk),
        .rst       (rst),
        .wdata_i   (ufp_rdata),
        .enqueue_i (enqueue),
        .dequeue_i (dequeue_i),
        .flush_i   (redirect_i),
        .rdata_o   (inst_o),
        .full_o    (iq_full),
        .empty_o   (iq_empty)
    );

    fetch_queue #(.DATA_WIDTH($bits(addr_t)), .QUEUE_DEPTH(`IQUEUE_DEPTH)) pcqueue_i (
        .clk       (clk),
        .rst       (rst),
        .wdata_i   (ufp_addr),          // still the request address when the response lands
        .enqueue_i (enqueue),
        .dequeue_i (dequeue_i),
        .flush_i   (redirect_i),
        .rdata_o   (pc_o),
        .full_o    (),
        .empty_o   ()
    );

    assign valid_o = !iq_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt_q <= '0;
        end else if (bmem_rvalid_i) begin
            beat_cnt_q <= (beat_cnt_q == BEAT_W'(`BURST_BEATS - 1)) ? '0 : beat_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bmem_read_o) begin
            line_addr_q <= bmem_addr_o;
        end
    end

    // beats come back in address order, 8 bytes apart
    assert property (@(posedge clk) disable iff (rst)
        bmem_rvalid_i |-> bmem_raddr_i == line_addr_q + addr_t'({beat_cnt_q, 3'b000}))
        else $error("cpu_frontend: beat address does not follow the issued line");

endmodule : cpu_frontend

// ==== hw/fetch_ctrl.sv ====
`timescale 1ns/1ps
`include "frontend_config.svh"

module fetch_ctrl (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    queue_full_i,
    input  logic                    ufp_resp_i,
    input  logic                    redirect_i,
    input  fetch_types_pkg::addr_t  redirect_addr_i,
    input  logic                    dfp_read_i,
    input  logic                    bmem_ready_i,

    output fetch_types_pkg::addr_t  ufp_addr_o,
    output logic                    ufp_rmask_o,
    output logic                    enqueue_o,
    output logic                    bmem_read_o
);

    import fetch_types_pkg::*;

    fetch_state_t state_q;
    fetch_state_t state_d;
    addr_t        pc_q;
    logic         stale_q;          // response in flight belongs to a pre-redirect fetch
    logic         dfp_read_q;
    logic         read_pend_q;      // rising edge seen but memory was busy
    logic         read_req;

    assign ufp_addr_o  = pc_q;
    assign ufp_rmask_o = (state_q != FETCH_WAIT) && !queue_full_i && bmem_ready_i && !redirect_i;
    assign enqueue_o   = ufp_resp_i && !stale_q && !redirect_i;

    // one bmem_read pulse per rising edge of dfp_read, deferred while not ready
    assign read_req    = dfp_read_i && (!dfp_read_q || read_pend_q);
    assign bmem_read_o = read_req && bmem_ready_i;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            FETCH_IDLE, FETCH_STALL: begin
                state_d = ufp_rmask_o ? FETCH_WAIT : FETCH_STALL;
            end
            FETCH_WAIT: begin
                if (ufp_resp_i) begin
                    state_d = FETCH_IDLE;       // next request goes out next cycle
                end
            end
            default: begin
                state_d = FETCH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= FETCH_IDLE;
            pc_q        <= `RESET_PC;
            stale_q     <= 1'b0;
            dfp_read_q  <= 1'b0;
            read_pend_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            dfp_read_q  <= dfp_read_i;
            read_pend_q <= read_req && !bmem_ready_i;
            if (redirect_i) begin
                pc_q <= redirect_addr_i;
            end else if (enqueue_o) begin
                pc_q <= pc_q + 32'd4;
            end
            if (ufp_resp_i) begin
                stale_q <= 1'b0;
            end else if (redirect_i && (state_q == FETCH_WAIT)) begin
                stale_q <= 1'b1;
            end
        end
    end

    // a response only answers the single request still outstanding
    assert property (@(posedge clk) disable iff (rst)
        ufp_resp_i |-> (state_q == FETCH_WAIT))
        else $error("fetch_ctrl: response without an outstanding request");

endmodule : fetch_ctrl

// ==== hw/fetch_queue.sv ====
`timescale 1ns/1ps

module fetch_queue #(
    parameter int DATA_WIDTH  = 32,
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic [DATA_WIDTH-1:0]  wdata_i,
    input  logic                   enqueue_i,
    input  logic                   dequeue_i,
    input  logic                   flush_i,

    output logic [DATA_WIDTH-1:0]  rdata_o,
    output logic                   full_o,
    output logic                   empty_o
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem_q [QUEUE_DEPTH];
    logic [PTR_W-1:0]      wr_ptr_q;
    logic [PTR_W-1:0]      rd_ptr_q;
    logic [CNT_W-1:0]      count_q;
    logic                  do_enq;
    logic                  do_deq;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o  = count_q == CNT_W'(QUEUE_DEPTH);
    assign empty_o = count_q == '0;

    assign do_enq = enqueue_i && !full_o;
    assign do_deq = dequeue_i && !empty_o;

    assign rdata_o = mem_q[rd_ptr_q];                  // head is visible the cycle after the write

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin                      // flush beats a same-cycle enqueue
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (do_deq) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            if (do_enq && !do_deq) begin
                count_q <= count_q + 1'b1;
            end else if (do_deq && !do_enq) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem_q[wr_ptr_q] <= wdata_i;
        end
    end

    // producer and consumer are expected to honor full and empty
    assert property (@(posedge clk) disable iff (rst)
        enqueue_i |-> !full_o)
        else $error("fetch_queue: enqueue while full");

    assert property (@(posedge clk) disable iff (rst)
        dequeue_i |-> !empty_o)
        else $error("fetch_queue: dequeue while empty");

endmodule : fetch_queue

// ==== hw/fetch_types_pkg.sv ====
package fetch_types_pkg;

    // byte address as seen by the fetch unit
    typedef logic [31:0] addr_t;

    // one rv32i instruction word
    typedef logic [31:0] inst_t;

    // fetch request sequencing
    typedef enum logic [1:0] {
        FETCH_IDLE,  // free to issue
        FETCH_WAIT,  // one request outstanding
        FETCH_STALL  // blocked by queue, memory or redirect
    } fetch_state_t;

endpackage : fetch_types_pkg

// ==== hw/frontend_config.svh ====
`ifndef FRONTEND_CONFIG_SVH
`define FRONTEND_CONFIG_SVH

// first fetch address out of reset
`define RESET_PC 32'h1eceb000

// entries in each instruction queue
`define IQUEUE_DEPTH 8

// direct-mapped sets in the icache
`define ICACHE_SETS 16

// 64-bit beats per cache line fill
`define BURST_BEATS 4

`endif

// ==== hw/icache.sv ====
`timescale 1ns/1ps
`include "frontend_config.svh"

module icache (
    input  logic                       clk,
    input  logic                       rst,

    input  fetch_types_pkg::addr_t     ufp_addr_i,
    input  logic                       ufp_rmask_i,
    output fetch_types_pkg::inst_t     ufp_rdata_o,
    output logic                       ufp_resp_o,

    output fetch_types_pkg::addr_t     dfp_addr_o,
    output logic                       dfp_read_o,
    input  mem_types_pkg::cacheline_t  dfp_rdata_i,
    input  logic                       dfp_resp_i
);

    import fetch_types_pkg::*;
    import mem_types_pkg::*;

    localparam int WORD_BITS = $bits(inst_t);

    cache_state_t              state_q;
    cache_state_t              state_d;
    addr_t                     addr_q;           // request address, held until the response

    tag_t                      tag_arr  [`ICACHE_SETS];
    cacheline_t                line_arr [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0]   valid_q;

    tag_t                      req_tag;
    index_t                    req_idx;
    logic [OFFSET_BITS-3:0]    req_word;         // word within the line
    logic                      hit;
    logic                      fill;

    assign req_tag  = addr_q[31 -: TAG_BITS];
    assign req_idx  = addr_q[OFFSET_BITS +: INDEX_BITS];
    assign req_word = addr_q[OFFSET_BITS-1:2];

    assign hit  = valid_q[req_idx] && (tag_arr[req_idx] == req_tag);
    assign fill = (state_q == C_MISS) && dfp_resp_i;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            C_IDLE: begin
                if (ufp_rmask_i) begin
                    state_d = C_LOOKUP;
                end
            end
            C_LOOKUP: begin
                state_d = hit ? C_IDLE : C_MISS;
            end
            C_MISS: begin
                if (dfp_resp_i) begin
                    state_d = C_FILL;
                end
            end
            C_FILL: begin
                state_d = C_IDLE;
            end
            default: begin
                state_d = C_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= C_IDLE;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            if (fill) begin
                valid_q[req_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == C_IDLE) && ufp_rmask_i) begin
            addr_q <= ufp_addr_i;
        end
        if (fill) begin
            tag_arr[req_idx]  <= req_tag;
            line_arr[req_idx] <= dfp_rdata_i;
        end
    end

    // hit answers from LOOKUP, a miss answers from FILL once the line is written
    assign ufp_resp_o  = ((state_q == C_LOOKUP) && hit) || (state_q == C_FILL);
    assign ufp_rdata_o = line_arr[req_idx][{req_word, 5'd0} +: WORD_BITS];

    assign dfp_read_o = state_q == C_MISS;                      // level, held until the line lands
    assign dfp_addr_o = {addr_q[31:OFFSET_BITS], OFFSET_BITS'(0)};

    // the adapter only returns a line for a read this cache asked for
    assert property (@(posedge clk) disable iff (rst)
        dfp_resp_i |-> dfp_read_o)
        else $error("icache: line returned without an open read");

endmodule : icache

// ==== hw/mem_types_pkg.sv ====
`include "frontend_config.svh"

package mem_types_pkg;

    localparam int OFFSET_BITS = 5;                          // 32 byte lines
    localparam int INDEX_BITS  = $clog2(`ICACHE_SETS);
    localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS;

    // one beat of the burst memory
    typedef logic [63:0] beat_t;

    // one full cache line
    typedef logic [255:0] cacheline_t;

    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;

    // icache miss handling
    typedef enum logic [1:0] {
        C_IDLE,
        C_LOOKUP,
        C_MISS,
        C_FILL
    } cache_state_t;

endpackage : mem_types_pkg

// ==== tb.f ====
+incdir+hw
hw/fetch_types_pkg.sv
hw/mem_types_pkg.sv
hw/cacheline_adapter.sv
hw/icache.sv
hw/fetch_queue.sv
hw/fetch_ctrl.sv
hw/cpu_frontend.sv
dv/bmem_model.sv
dv/tb_cpu_frontend.sv
